//--- src/srrc_coefs.svh
`ifndef SRRC_COEFS_SVH
`define SRRC_COEFS_SVH

// Square-root raised cosine with rolloff 0.35 and 4 samples per symbol
// Entry k weights taps k and 32-k and entry 16 is the centre tap alone
// Scaled so the centre tap sits near one half
localparam logic signed [COEF_W-1:0] SRRC_COEF [NUM_UNIQUE] = '{
    18'sd120,
    18'sd796,
    18'sd574,
    -18'sd568,
    -18'sd1525,
    -18'sd885,
    18'sd1531,
    18'sd3906,
    18'sd3416,
    -18'sd1292,
    -18'sd8088,
    -18'sd11282,
    -18'sd5067,
    18'sd12383,
    18'sd36354,
    18'sd57315,
    18'sd65541
};

`endif

//--- src/rx_pkg.sv
`default_nettype none

package rx_pkg;

    // Input samples and filter outputs, signed Q1.17
    localparam int SAMPLE_W = 18;

    // Filter coefficients, signed Q1.17
    localparam int COEF_W = 18;

    // Symmetric SRRC length
    // 8 symbols at 4 samples per symbol plus the centre tap
    localparam int NUM_TAPS = 33;

    // Distinct coefficients left after folding
    // The last index is the centre tap
    localparam int NUM_UNIQUE = (NUM_TAPS + 1) / 2;

    // Adder tree width
    // Holds the sum of 17 truncated products without wrapping
    localparam int ACC_W = 24;

    // Cycles from an accepted sample to its filter output
    localparam int FILT_LATENCY = 5;

endpackage

`default_nettype wire

//--- src/srrc_rx_filter.sv
`timescale 1ns/1ps
`default_nettype none

module srrc_rx_filter
    import rx_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] in_sample,
    output logic                       out_valid,
    output logic signed [SAMPLE_W-1:0] out_sample
);

    `include "srrc_coefs.svh"

    // Folded pair sum needs one extra bit
    localparam int FOLD_W = SAMPLE_W + 1;
    localparam int PROD_W = FOLD_W + COEF_W;

    // First tree level adds products in groups of four
    localparam int GROUP = 4;
    localparam int NUM_GROUPS = (NUM_UNIQUE + GROUP - 1) / GROUP;

    localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((1 << (SAMPLE_W - 1)) - 1);
    localparam logic signed [ACC_W-1:0] SAT_MIN = ~SAT_MAX;

    logic [FILT_LATENCY-1:0]    valid_pipe;
    logic signed [SAMPLE_W-1:0] taps [NUM_TAPS];
    logic signed [FOLD_W-1:0]   fold [NUM_UNIQUE];
    logic signed [PROD_W-1:0]   full_prod [NUM_UNIQUE];
    logic signed [ACC_W-1:0]    prod [NUM_UNIQUE];
    logic signed [ACC_W-1:0]    group_sum [NUM_GROUPS];
    logic signed [ACC_W-1:0]    tree_sum;
    logic signed [ACC_W-1:0]    acc_sum;

    // One valid bit per stage while the data stages below run every cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[FILT_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[FILT_LATENCY-1];

    // Stage 1 is the delay line with the newest sample at tap 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (in_valid) begin
            taps[0] <= in_sample;
            for (int i = 1; i < NUM_TAPS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // Stage 2 folds the symmetric taps
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_UNIQUE - 1; k++) begin
            fold[k] <= FOLD_W'(taps[k]) + FOLD_W'(taps[NUM_TAPS-1-k]);
        end
        fold[NUM_UNIQUE-1] <= FOLD_W'(taps[NUM_UNIQUE-1]);
    end

    // Stage 3 has one multiplier per distinct coefficient
    always_comb begin
        for (int k = 0; k < NUM_UNIQUE; k++) begin
            full_prod[k] = fold[k] * SRRC_COEF[k];
        end
    end

    // Arithmetic shift drops the Q1.17 fraction of the coefficient
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_UNIQUE; k++) begin
            prod[k] <= ACC_W'(full_prod[k] >>> (COEF_W - 1));
        end
    end

    // Stage 4 runs two adder levels in a single cycle
    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            group_sum[g] = '0;
            for (int j = 0; j < GROUP; j++) begin
                if (GROUP * g + j < NUM_UNIQUE) begin
                    group_sum[g] = group_sum[g] + prod[GROUP*g+j];
                end
            end
        end
        tree_sum = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            tree_sum = tree_sum + group_sum[g];
        end
    end

    always_ff @(posedge clk) begin
        acc_sum <= tree_sum;
    end

    // Stage 5 clamps to the sample range
    always_ff @(posedge clk) begin
        if (acc_sum > SAT_MAX) begin
            out_sample <= SAMPLE_W'(SAT_MAX);
        end else if (acc_sum < SAT_MIN) begin
            out_sample <= SAMPLE_W'(SAT_MIN);
        end else begin
            out_sample <= SAMPLE_W'(acc_sum);
        end
    end

endmodule

`default_nettype wire

//--- src/symbol_slicer.sv
`timescale 1ns/1ps
`default_nettype none

module symbol_slicer
    import rx_pkg::*;
#(
    parameter int SAMPLES_PER_SYMBOL = 4,
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDIT_INIT = 2,
    localparam int PHASE_W = (SAMPLES_PER_SYMBOL > 1) ? $clog2(SAMPLES_PER_SYMBOL) : 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       filt_valid,
    input  logic signed [SAMPLE_W-1:0] filt_i,
    input  logic signed [SAMPLE_W-1:0] filt_q,
    input  logic [PHASE_W-1:0]         sym_phase,
    input  logic                       credit_return,
    output logic                       sym_valid,
    output logic signed [SAMPLE_W-1:0] sym_i,
    output logic signed [SAMPLE_W-1:0] sym_q,
    output logic [1:0]                 sym_bits,
    output logic [15:0]                overflow_count
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);
    // One spare count of headroom above the initial credits
    localparam int CREDIT_W = $clog2(CREDIT_INIT + 2);

    logic [PHASE_W-1:0]         phase_cnt;
    logic                       take;
    logic                       send;
    logic                       full;
    logic                       push;
    logic                       drop;
    logic [1:0]                 decision;
    logic signed [SAMPLE_W-1:0] queue_i [QUEUE_DEPTH];
    logic signed [SAMPLE_W-1:0] queue_q [QUEUE_DEPTH];
    logic [1:0]                 queue_bits [QUEUE_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [COUNT_W-1:0]         count;
    logic [CREDIT_W-1:0]        credits;

    // Sample counter within the symbol period
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase_cnt <= '0;
        end else if (filt_valid) begin
            if (phase_cnt == PHASE_W'(SAMPLES_PER_SYMBOL - 1)) begin
                phase_cnt <= '0;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    assign take = filt_valid && (phase_cnt == sym_phase);

    // Hard QPSK decision from the sign bits
    assign decision = {filt_i[SAMPLE_W-1], filt_q[SAMPLE_W-1]};

    assign send = (count != '0) && (credits != '0);
    assign full = (count == COUNT_W'(QUEUE_DEPTH));
    // A send in the same cycle frees the slot for the new symbol
    assign push = take && (!full || send);
    assign drop = take && !push;

    always_ff @(posedge clk) begin
        if (push) begin
            queue_i[wr_ptr] <= filt_i;
            queue_q[wr_ptr] <= filt_q;
            queue_bits[wr_ptr] <= decision;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (send) begin
                if (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Each send spends a credit, each return pulse gives one back
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= CREDIT_W'(CREDIT_INIT);
        end else begin
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            overflow_count <= '0;
        end else if (drop && (overflow_count != 16'hffff)) begin
            overflow_count <= overflow_count + 1'b1;
        end
    end

    assign sym_valid = send;
    assign sym_i = queue_i[rd_ptr];
    assign sym_q = queue_q[rd_ptr];
    assign sym_bits = queue_bits[rd_ptr];

endmodule

`default_nettype wire

//--- src/qpsk_rx_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module qpsk_rx_frontend
    import rx_pkg::*;
#(
    parameter int SAMPLES_PER_SYMBOL = 4,
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDIT_INIT = 2,
    localparam int PHASE_W = (SAMPLES_PER_SYMBOL > 1) ? $clog2(SAMPLES_PER_SYMBOL) : 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sample_valid,
    input  logic signed [SAMPLE_W-1:0] sample_i,
    input  logic signed [SAMPLE_W-1:0] sample_q,
    input  logic [PHASE_W-1:0]         sym_phase,
    input  logic                       credit_return,
    output logic                       sym_valid,
    output logic signed [SAMPLE_W-1:0] sym_i,
    output logic signed [SAMPLE_W-1:0] sym_q,
    output logic [1:0]                 sym_bits,
    output logic [15:0]                overflow_count
);

    logic                       filt_valid;
    logic signed [SAMPLE_W-1:0] filt_i;
    logic signed [SAMPLE_W-1:0] filt_q;

    // Both channels see the same valid, so their outputs stay aligned
    srrc_rx_filter filter_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (sample_valid),
        .in_sample  (sample_i),
        .out_valid  (filt_valid),
        .out_sample (filt_i)
    );

    // Q valid matches the I valid
    srrc_rx_filter filter_q (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (sample_valid),
        .in_sample  (sample_q),
        .out_valid  (),
        .out_sample (filt_q)
    );

    symbol_slicer #(
        .SAMPLES_PER_SYMBOL (SAMPLES_PER_SYMBOL),
        .QUEUE_DEPTH        (QUEUE_DEPTH),
        .CREDIT_INIT        (CREDIT_INIT)
    ) slicer (
        .clk            (clk),
        .reset          (reset),
        .filt_valid     (filt_valid),
        .filt_i         (filt_i),
        .filt_q         (filt_q),
        .sym_phase      (sym_phase),
        .credit_return  (credit_return),
        .sym_valid      (sym_valid),
        .sym_i          (sym_i),
        .sym_q          (sym_q),
        .sym_bits       (sym_bits),
        .overflow_count (overflow_count)
    );

endmodule

`default_nettype wire

//--- verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// SRRC weights where entry k serves taps k and 32-k and the last entry the centre tap
localparam int REF_COEF [NUM_UNIQUE] = '{
    120, 796, 574, -568, -1525, -885, 1531, 3906, 3416,
    -1292, -8088, -11282, -5067, 12383, 36354, 57315, 65541
};
localparam int REF_MAX = (1 << (SAMPLE_W - 1)) - 1;
localparam int REF_MIN = -(1 << (SAMPLE_W - 1));

// Sample history per channel with the newest at index 0
int hist_i [NUM_TAPS];
int hist_q [NUM_TAPS];

function automatic void clear_history();
    for (int t = 0; t < NUM_TAPS; t++) begin
        hist_i[t] = 0;
        hist_q[t] = 0;
    end
endfunction

function automatic void push_history(input int si, input int sq);
    for (int t = NUM_TAPS - 1; t > 0; t--) begin
        hist_i[t] = hist_i[t-1];
        hist_q[t] = hist_q[t-1];
    end
    hist_i[0] = si;
    hist_q[0] = sq;
endfunction

function automatic longint tap_value(input bit chan_q, input int t);
    return chan_q ? longint'(hist_q[t]) : longint'(hist_i[t]);
endfunction

// Fold, multiply, drop 17 fraction bits, sum, clip to the sample range
function automatic int filter_output(input bit chan_q);
    longint acc;
    longint folded;
    acc = 0;
    for (int k = 0; k < NUM_UNIQUE; k++) begin
        folded = tap_value(chan_q, k);
        if (k < NUM_UNIQUE - 1) begin
            folded += tap_value(chan_q, NUM_TAPS - 1 - k);
        end
        acc += (folded * REF_COEF[k]) >>> (COEF_W - 1);
    end
    if (acc > REF_MAX) begin
        return REF_MAX;
    end else if (acc < REF_MIN) begin
        return REF_MIN;
    end
    return int'(acc);
endfunction

function automatic bit on_symbol_phase(input int count, input int phase);
    return (count % SAMPLES_PER_SYMBOL) == phase;
endfunction

// Bit 1 from the I sign, bit 0 from the Q sign
function automatic logic [1:0] hard_decision(input int si, input int sq);
    return {si < 0, sq < 0};
endfunction

`endif

//--- verification/tb_qpsk_rx_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qpsk_rx_frontend
    import rx_pkg::*;
();

    localparam int SAMPLES_PER_SYMBOL = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int CREDIT_INIT = 2;
    localparam int PHASE_W = $clog2(SAMPLES_PER_SYMBOL);
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int CREDIT_DELAY = 3;
    localparam int DRAIN_LIMIT = 200;
    localparam int IMPULSE_LEN = 41;
    localparam int RANDOM_LEN = 400;
    localparam int BP_LEN = 48;
    localparam int SAT_LEN = 41;
    localparam int TOTAL_SAMPLES = 4 * IMPULSE_LEN + 2 * RANDOM_LEN + BP_LEN + SAT_LEN;
    localparam int WATCHDOG_NS = (TOTAL_SAMPLES * 2 + 500) * CLK_PERIOD;
    localparam logic [31:0] SEED_INIT = 32'hf0d138ce;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       sample_valid;
    logic signed [SAMPLE_W-1:0] sample_i;
    logic signed [SAMPLE_W-1:0] sample_q;
    logic [PHASE_W-1:0]         sym_phase;
    logic                       credit_return;
    logic                       sym_valid;
    logic signed [SAMPLE_W-1:0] sym_i;
    logic signed [SAMPLE_W-1:0] sym_q;
    logic [1:0]                 sym_bits;
    logic [15:0]                overflow_count;

    integer     seed;
    string      test_name;
    bit         withhold;
    int         cycle = 0;
    int         cur_phase;
    int         accept_count;
    int         num_decimated;
    int         kept;
    int         keep_limit = -1;
    int         sat_hits;
    int         rx_count = 0;
    int         err_value = 0;
    int         err_other = 0;
    int         exp_i [$];
    int         exp_q [$];
    logic [1:0] exp_bits [$];
    int         credit_due [$];

    qpsk_rx_frontend #(
        .SAMPLES_PER_SYMBOL (SAMPLES_PER_SYMBOL),
        .QUEUE_DEPTH        (QUEUE_DEPTH),
        .CREDIT_INIT        (CREDIT_INIT)
    ) qpsk_rx_frontend_i (
        .clk            (clk),
        .reset          (reset),
        .sample_valid   (sample_valid),
        .sample_i       (sample_i),
        .sample_q       (sample_q),
        .sym_phase      (sym_phase),
        .credit_return  (credit_return),
        .sym_valid      (sym_valid),
        .sym_i          (sym_i),
        .sym_q          (sym_q),
        .sym_bits       (sym_bits),
        .overflow_count (overflow_count)
    );

    `include "tb_ref_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Queue the expected symbol unless it lies past the surviving limit
    function automatic void model_accept(input int si, input int sq);
        int fi;
        int fq;
        push_history(si, sq);
        fi = filter_output(1'b0);
        fq = filter_output(1'b1);
        if (on_symbol_phase(accept_count, cur_phase)) begin
            num_decimated++;
            if (fi == REF_MAX || fi == REF_MIN || fq == REF_MAX || fq == REF_MIN) begin
                sat_hits++;
            end
            if (keep_limit < 0 || kept < keep_limit) begin
                exp_i.push_back(fi);
                exp_q.push_back(fq);
                exp_bits.push_back(hard_decision(fi, fq));
                kept++;
            end
        end
        accept_count++;
    endfunction

    task automatic drive_sample(input bit valid, input int si, input int sq);
        @(posedge clk);
        #2;
        sample_valid = valid;
        sample_i = SAMPLE_W'(si);
        sample_q = SAMPLE_W'(sq);
        if (valid) begin
            model_accept(si, sq);
        end
    endtask

    task automatic drive_random(input bit valid);
        int si;
        int sq;
        si = $random(seed) % (REF_MAX + 1);
        sq = $random(seed) % (REF_MAX + 1);
        drive_sample(valid, si, sq);
    endtask

    task automatic reset_dut(input int phase);
        reset = 1'b1;
        sample_valid = 1'b0;
        sym_phase = PHASE_W'(phase);
        cur_phase = phase;
        clear_history();
        accept_count = 0;
        num_decimated = 0;
        kept = 0;
        sat_hits = 0;
        credit_due.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (overflow_count == 16'd0) else begin
                $display("ERR %s overflow_count expected 0 actual %0d", test_name, overflow_count);
                err_value++;
            end
        end
        @(posedge clk);
        #2;
    endtask

    // Wait for every expected symbol and every returned credit
    task automatic wait_drain(input int exp_overflow);
        int waited;
        waited = 0;
        drive_sample(1'b0, 0, 0);
        repeat (FILT_LATENCY + 2) @(posedge clk);
        while ((exp_i.size() != 0 || credit_due.size() != 0) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        #2;
        assert (exp_i.size() == 0) else begin
            $display("Symbols missing in %s, %0d never sent", test_name, exp_i.size());
            err_other++;
        end
        assert (int'(overflow_count) == exp_overflow) else begin
            $display("ERR %s overflow_count expected %0d actual %0d", test_name,
                     exp_overflow, overflow_count);
            err_value++;
        end
        exp_i.delete();
        exp_q.delete();
        exp_bits.delete();
    endtask

    task automatic run_random(input int phase);
        int accepted;
        bit valid;
        accepted = 0;
        seed = SEED_INIT;
        reset_dut(phase);
        while (accepted < RANDOM_LEN) begin
            valid = ($random(seed) & 3) != 0;
            drive_random(valid);
            accepted += int'(valid);
        end
        wait_drain(0);
    endtask

    // Full scale with the sign of the coefficient that weights tap n
    function automatic int sat_level(input int n);
        int idx;
        idx = (n < NUM_UNIQUE) ? n : NUM_TAPS - 1 - n;
        return (REF_COEF[idx] < 0) ? REF_MIN + 1 : REF_MAX;
    endfunction

    always @(negedge clk) begin : compare
        int exp_si;
        int exp_sq;
        logic [1:0] exp_b;
        if (reset) begin
            assert (!sym_valid && overflow_count == 16'd0) else begin
                $display("Outputs not idle while reset is held in %s", test_name);
                err_other++;
            end
        end else if (sym_valid) begin
            rx_count++;
            credit_due.push_back(cycle + CREDIT_DELAY);
            assert (exp_i.size() != 0) else begin
                $display("Extra symbol in %s with no reference symbol pending", test_name);
                err_other++;
            end
            if (exp_i.size() != 0) begin
                exp_si = exp_i.pop_front();
                exp_sq = exp_q.pop_front();
                exp_b = exp_bits.pop_front();
                assert (int'(sym_i) == exp_si) else begin
                    $display("ERR %s sym_i expected %0d actual %0d", test_name, exp_si, sym_i);
                    err_value++;
                end
                assert (int'(sym_q) == exp_sq) else begin
                    $display("ERR %s sym_q expected %0d actual %0d", test_name, exp_sq, sym_q);
                    err_value++;
                end
                assert (sym_bits == exp_b) else begin
                    $display("ERR %s sym_bits expected %b actual %b", test_name, exp_b, sym_bits);
                    err_value++;
                end
            end
        end
    end

    // One credit back a few cycles after each received symbol
    initial begin
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (!withhold && credit_due.size() != 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                credit_return = 1'b1;
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main_flow
        int rx_before;
        reset = 1'b1;
        sample_valid = 1'b0;
        sample_i = '0;
        sample_q = '0;
        sym_phase = '0;
        withhold = 1'b0;
        seed = SEED_INIT;
        test_name = "reset";
        reset_dut(0);
        check_idle(5);

        test_name = "impulse";
        for (int ph = 0; ph < SAMPLES_PER_SYMBOL; ph++) begin
            reset_dut(ph);
            for (int n = 0; n < IMPULSE_LEN; n++) begin
                if (n == 4) begin
                    drive_sample(1'b1, 65536, -65536);
                end else begin
                    drive_sample(1'b1, 0, 0);
                end
            end
            wait_drain(0);
        end

        test_name = "random";
        run_random(0);
        test_name = "phase";
        run_random(2);

        // Credits held back until the queue has overflowed
        test_name = "backpressure";
        reset_dut(0);
        withhold = 1'b1;
        keep_limit = CREDIT_INIT + QUEUE_DEPTH;
        rx_before = rx_count;
        for (int n = 0; n < BP_LEN; n++) begin
            drive_random(1'b1);
        end
        drive_sample(1'b0, 0, 0);
        repeat (FILT_LATENCY + 2) @(posedge clk);
        #2;
        assert (rx_count - rx_before == CREDIT_INIT) else begin
            $display("ERR %s sent count expected %0d actual %0d", test_name, CREDIT_INIT,
                     rx_count - rx_before);
            err_value++;
        end
        withhold = 1'b0;
        wait_drain(num_decimated - keep_limit);
        keep_limit = -1;

        test_name = "saturation";
        reset_dut(0);
        for (int n = 0; n < SAT_LEN; n++) begin
            if (n < NUM_TAPS) begin
                drive_sample(1'b1, sat_level(n), -sat_level(n));
            end else begin
                drive_sample(1'b1, 0, 0);
            end
        end
        wait_drain(0);
        assert (sat_hits > 0) else begin
            $display("Saturation stimulus produced no clipped reference symbol");
            err_other++;
        end

        $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
+incdir+verification
src/rx_pkg.sv
src/srrc_rx_filter.sv
src/symbol_slicer.sv
src/qpsk_rx_frontend.sv
verification/tb_qpsk_rx_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the QPSK receive front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_qpsk_rx_frontend \
    --Mdir obj_dir -o tb_qpsk_rx_frontend \
    -f build.f

./obj_dir/tb_qpsk_rx_frontend | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run reported errors, see sim.log"
    exit 1
fi
echo "Run clean"
